/* include/raster_settings.svh */
`ifndef RASTER_SETTINGS_SVH
`define RASTER_SETTINGS_SVH

// Screen coordinate width in bits
`define RASTER_COORD_W 10

// Line queue entries, also the clipper's line credits after reset
`define RASTER_QUEUE_DEPTH 4

// Queue pointer width, log2 of the depth
`define RASTER_QUEUE_PTR_W 2

// Pixel credits the walker holds after reset
`define RASTER_PX_CREDITS 4

`endif

/* rtl/raster_geom_pkg.sv */
`default_nettype none

`include "raster_settings.svh"

package raster_geom_pkg;

	// Screen position on either axis
	typedef logic [`RASTER_COORD_W-1:0] coord_t;

	// Absolute difference between two coordinates
	typedef logic [`RASTER_COORD_W-1:0] delta_t;

	// Palette index of a pixel
	typedef logic [2:0] color_t;

	// Octant flags {steep, minor step negative, endpoints swapped}
	typedef logic [2:0] octant_t;

	// Bit positions inside octant_t
	localparam int OCT_STEEP = 2;
	localparam int OCT_NEG   = 1;
	localparam int OCT_SWAP  = 0;

endpackage

`default_nettype wire

/* rtl/raster_ctl_pkg.sv */
`default_nettype none

`include "raster_settings.svh"

package raster_ctl_pkg;

	// Walker FSM, LOAD sets up the walk for the popped line
	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		STEP
	} walker_state_t;

	// Pixel credits on hand, must reach RASTER_PX_CREDITS
	typedef logic [3:0] credit_cnt_t;

	// Queue occupancy, 0 up to RASTER_QUEUE_DEPTH
	typedef logic [2:0] qcount_t;

	typedef logic [`RASTER_QUEUE_PTR_W-1:0] qptr_t;

endpackage

`default_nettype wire

/* rtl/line_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module line_capture (
	input  wire                     clk,
	input  wire                     rst,
	input  wire                     line_valid,
	input  wire raster_geom_pkg::coord_t x0,
	input  wire raster_geom_pkg::coord_t y0,
	input  wire raster_geom_pkg::coord_t x1,
	input  wire raster_geom_pkg::coord_t y1,
	input  wire raster_geom_pkg::color_t color,
	input  wire                     end_obj,
	output logic                    cap_valid,
	output raster_geom_pkg::coord_t cap_x0,
	output raster_geom_pkg::coord_t cap_y0,
	output raster_geom_pkg::coord_t cap_x1,
	output raster_geom_pkg::coord_t cap_y1,
	output raster_geom_pkg::color_t cap_color,
	output logic                    cap_end
);

	// Valid bit of the first pipeline stage
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			cap_valid <= 1'b0;
		end
		else
		begin
			cap_valid <= line_valid;
		end
	end

	// Line fields, only loaded when the clipper sends
	always_ff @(posedge clk)
	begin
		if (line_valid)
		begin
			cap_x0    <= x0;
			cap_y0    <= y0;
			cap_x1    <= x1;
			cap_y1    <= y1;
			cap_color <= color;
			cap_end   <= end_obj;
		end
	end

endmodule

`default_nettype wire

/* rtl/octant_classifier.sv */
`timescale 1ns/1ps
`default_nettype none

module octant_classifier (
	input  wire                      clk,
	input  wire                      rst,
	input  wire                      cap_valid,
	input  wire raster_geom_pkg::coord_t cap_x0,
	input  wire raster_geom_pkg::coord_t cap_y0,
	input  wire raster_geom_pkg::coord_t cap_x1,
	input  wire raster_geom_pkg::coord_t cap_y1,
	input  wire raster_geom_pkg::color_t cap_color,
	input  wire                      cap_end,
	output logic                     cls_valid,
	output raster_geom_pkg::coord_t  cls_x0,
	output raster_geom_pkg::coord_t  cls_y0,
	output raster_geom_pkg::coord_t  cls_x1,
	output raster_geom_pkg::coord_t  cls_y1,
	output raster_geom_pkg::color_t  cls_color,
	output logic                     cls_end,
	output raster_geom_pkg::delta_t  cls_dx,
	output raster_geom_pkg::delta_t  cls_dy,
	output raster_geom_pkg::octant_t cls_octant
);
	import raster_geom_pkg::*;

	logic    x_dec;
	logic    x_inc;
	logic    y_dec;
	logic    y_inc;
	delta_t  abs_dx;
	delta_t  abs_dy;
	octant_t octant;

	// Direction of each axis going from end 0 to end 1
	assign x_dec = cap_x1 < cap_x0;
	assign x_inc = cap_x1 > cap_x0;
	assign y_dec = cap_y1 < cap_y0;
	assign y_inc = cap_y1 > cap_y0;

	assign abs_dx = x_dec ? cap_x0 - cap_x1 : cap_x1 - cap_x0;
	assign abs_dy = y_dec ? cap_y0 - cap_y1 : cap_y1 - cap_y0;

	always_comb
	begin
		octant[OCT_STEEP] = abs_dy > abs_dx;
		// Walk must go forward on the major axis
		octant[OCT_SWAP] = octant[OCT_STEEP] ? y_dec : x_dec;
		// Minor direction seen from the end the walk starts at
		if (octant[OCT_STEEP])
			octant[OCT_NEG] = octant[OCT_SWAP] ? x_inc : x_dec;
		else
			octant[OCT_NEG] = octant[OCT_SWAP] ? y_inc : y_dec;
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			cls_valid <= 1'b0;
		else
			cls_valid <= cap_valid;
	end

	always_ff @(posedge clk)
	begin
		if (cap_valid)
		begin
			cls_x0     <= cap_x0;
			cls_y0     <= cap_y0;
			cls_x1     <= cap_x1;
			cls_y1     <= cap_y1;
			cls_color  <= cap_color;
			cls_end    <= cap_end;
			cls_dx     <= abs_dx;
			cls_dy     <= abs_dy;
			cls_octant <= octant;
		end
	end

endmodule

`default_nettype wire

/* rtl/endpoint_normalizer.sv */
`timescale 1ns/1ps
`default_nettype none

module endpoint_normalizer (
	input  wire                      clk,
	input  wire                      rst,
	input  wire                      cls_valid,
	input  wire raster_geom_pkg::coord_t  cls_x0,
	input  wire raster_geom_pkg::coord_t  cls_y0,
	input  wire raster_geom_pkg::coord_t  cls_x1,
	input  wire raster_geom_pkg::coord_t  cls_y1,
	input  wire raster_geom_pkg::color_t  cls_color,
	input  wire                      cls_end,
	input  wire raster_geom_pkg::delta_t  cls_dx,
	input  wire raster_geom_pkg::delta_t  cls_dy,
	input  wire raster_geom_pkg::octant_t cls_octant,
	output logic                     nrm_valid,
	output raster_geom_pkg::coord_t  nrm_sx,
	output raster_geom_pkg::coord_t  nrm_sy,
	output raster_geom_pkg::delta_t  nrm_major,
	output raster_geom_pkg::delta_t  nrm_minor,
	output raster_geom_pkg::octant_t nrm_octant,
	output raster_geom_pkg::color_t  nrm_color,
	output logic                     nrm_end
);
	import raster_geom_pkg::*;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			nrm_valid <= 1'b0;
		else
			nrm_valid <= cls_valid;
	end

	always_ff @(posedge clk)
	begin
		if (cls_valid)
		begin
			// Start from whichever end is lower on the major axis
			nrm_sx <= cls_octant[OCT_SWAP] ? cls_x1 : cls_x0;
			nrm_sy <= cls_octant[OCT_SWAP] ? cls_y1 : cls_y0;
			nrm_major  <= cls_octant[OCT_STEEP] ? cls_dy : cls_dx;
			nrm_minor  <= cls_octant[OCT_STEEP] ? cls_dx : cls_dy;
			nrm_octant <= cls_octant;
			nrm_color  <= cls_color;
			nrm_end    <= cls_end;
		end
	end

endmodule

`default_nettype wire

/* rtl/line_queue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "raster_settings.svh"

module line_queue (
	input  wire                      clk,
	input  wire                      rst,
	input  wire                      nrm_valid,
	input  wire raster_geom_pkg::coord_t  nrm_sx,
	input  wire raster_geom_pkg::coord_t  nrm_sy,
	input  wire raster_geom_pkg::delta_t  nrm_major,
	input  wire raster_geom_pkg::delta_t  nrm_minor,
	input  wire raster_geom_pkg::octant_t nrm_octant,
	input  wire raster_geom_pkg::color_t  nrm_color,
	input  wire                      nrm_end,
	input  wire                      q_pop,
	output logic                     q_empty,
	output raster_geom_pkg::coord_t  q_sx,
	output raster_geom_pkg::coord_t  q_sy,
	output raster_geom_pkg::delta_t  q_major,
	output raster_geom_pkg::delta_t  q_minor,
	output raster_geom_pkg::octant_t q_octant,
	output raster_geom_pkg::color_t  q_color,
	output logic                     q_end,
	output logic                     line_credit
);
	import raster_geom_pkg::*;
	import raster_ctl_pkg::*;

	localparam int DEPTH = `RASTER_QUEUE_DEPTH;

	coord_t  mem_sx     [DEPTH];
	coord_t  mem_sy     [DEPTH];
	delta_t  mem_major  [DEPTH];
	delta_t  mem_minor  [DEPTH];
	octant_t mem_octant [DEPTH];
	color_t  mem_color  [DEPTH];
	logic    mem_end    [DEPTH];
	qptr_t   wr_ptr;
	qptr_t   rd_ptr;
	qcount_t count;

	always_ff @(posedge clk)
	begin
		if (nrm_valid)
		begin
			mem_sx[wr_ptr]     <= nrm_sx;
			mem_sy[wr_ptr]     <= nrm_sy;
			mem_major[wr_ptr]  <= nrm_major;
			mem_minor[wr_ptr]  <= nrm_minor;
			mem_octant[wr_ptr] <= nrm_octant;
			mem_color[wr_ptr]  <= nrm_color;
			mem_end[wr_ptr]    <= nrm_end;
		end
	end

	// Pointers wrap on their own, depth is a power of two
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			count       <= '0;
			line_credit <= 1'b0;
		end
		else
		begin
			if (nrm_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (q_pop)
				rd_ptr <= rd_ptr + 1'b1;
			count       <= count + qcount_t'(nrm_valid) - qcount_t'(q_pop);
			line_credit <= q_pop;
		end
	end

	assign q_empty  = (count == '0);
	assign q_sx     = mem_sx[rd_ptr];
	assign q_sy     = mem_sy[rd_ptr];
	assign q_major  = mem_major[rd_ptr];
	assign q_minor  = mem_minor[rd_ptr];
	assign q_octant = mem_octant[rd_ptr];
	assign q_color  = mem_color[rd_ptr];
	assign q_end    = mem_end[rd_ptr];

	// Clipper credits must keep the queue from filling past its depth
	a_no_overflow: assert property (@(posedge clk) disable iff (!rst)
		nrm_valid |-> (count < qcount_t'(DEPTH)));

	// Walker only pops a line it can see
	a_no_underflow: assert property (@(posedge clk) disable iff (!rst)
		q_pop |-> !q_empty);

endmodule

`default_nettype wire

/* rtl/bresenham_walker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "raster_settings.svh"

module bresenham_walker (
	input  wire                      clk,
	input  wire                      rst,
	input  wire                      q_empty,
	input  wire raster_geom_pkg::coord_t  q_sx,
	input  wire raster_geom_pkg::coord_t  q_sy,
	input  wire raster_geom_pkg::delta_t  q_major,
	input  wire raster_geom_pkg::delta_t  q_minor,
	input  wire raster_geom_pkg::octant_t q_octant,
	input  wire raster_geom_pkg::color_t  q_color,
	input  wire                      q_end,
	output logic                     q_pop,
	input  wire                      px_credit,
	output logic                     px_valid,
	output raster_geom_pkg::coord_t  px_x,
	output raster_geom_pkg::coord_t  px_y,
	output raster_geom_pkg::color_t  px_color,
	output logic                     obj_done
);
	import raster_geom_pkg::*;
	import raster_ctl_pkg::*;

	// Decision term needs two extra bits for 2*delta plus a sign
	localparam int ERR_W = `RASTER_COORD_W + 3;

	walker_state_t           state;
	credit_cnt_t             credits;
	coord_t                  l_sx;
	coord_t                  l_sy;
	delta_t                  l_major;
	delta_t                  l_minor;
	logic                    l_steep;
	logic                    l_neg;
	logic                    l_end;
	color_t                  l_color;
	coord_t                  maj_pos;
	coord_t                  min_pos;
	delta_t                  remain;
	logic signed [ERR_W-1:0] err;
	logic signed [ERR_W-1:0] two_major;
	logic signed [ERR_W-1:0] two_minor;
	logic signed [ERR_W-1:0] major_ext;
	logic                    last_px;

	assign two_major = $signed({2'b00, l_major, 1'b0});
	assign two_minor = $signed({2'b00, l_minor, 1'b0});
	assign major_ext = $signed({3'b000, l_major});

	assign q_pop    = (state == IDLE) && !q_empty;
	assign px_valid = (state == STEP) && (credits != '0);
	assign last_px  = px_valid && (remain == '0);
	assign px_x     = l_steep ? min_pos : maj_pos;
	assign px_y     = l_steep ? maj_pos : min_pos;
	assign px_color = l_color;
	assign obj_done = last_px && l_end;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			state <= IDLE;
		else
		begin
			case (state)
				IDLE: if (!q_empty) state <= LOAD;
				LOAD: state <= STEP;
				STEP: if (last_px) state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// Grant and spend may land in the same cycle
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			credits <= credit_cnt_t'(`RASTER_PX_CREDITS);
		else if (px_credit && !px_valid)
			credits <= credits + 1'b1;
		else if (!px_credit && px_valid)
			credits <= credits - 1'b1;
	end

	// Head of queue taken on the pop edge
	always_ff @(posedge clk)
	begin
		if (q_pop)
		begin
			l_sx    <= q_sx;
			l_sy    <= q_sy;
			l_major <= q_major;
			l_minor <= q_minor;
			l_steep <= q_octant[OCT_STEEP];
			l_neg   <= q_octant[OCT_NEG];
			l_end   <= q_end;
			l_color <= q_color;
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == LOAD)
		begin
			maj_pos <= l_steep ? l_sy : l_sx;
			min_pos <= l_steep ? l_sx : l_sy;
			remain  <= l_major;
			err     <= two_minor - major_ext;
		end
		else if (px_valid)
		begin
			maj_pos <= maj_pos + 1'b1;
			remain  <= remain - 1'b1;
			if (err > 0)
			begin
				min_pos <= l_neg ? min_pos - 1'b1 : min_pos + 1'b1;
				err     <= err - two_major + two_minor;
			end
			else
				err <= err + two_minor;
		end
	end

	// Frame buffer never grants more than the walker started with
	a_credit_bound: assert property (@(posedge clk) disable iff (!rst)
		credits <= credit_cnt_t'(`RASTER_PX_CREDITS));

endmodule

`default_nettype wire

/* rtl/rasterizer_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rasterizer_top (
	input  wire                     clk,
	input  wire                     rst,
	input  wire                     line_valid,
	input  wire raster_geom_pkg::coord_t x0,
	input  wire raster_geom_pkg::coord_t y0,
	input  wire raster_geom_pkg::coord_t x1,
	input  wire raster_geom_pkg::coord_t y1,
	input  wire raster_geom_pkg::color_t color,
	input  wire                     end_obj,
	output logic                    line_credit,
	input  wire                     px_credit,
	output logic                    px_valid,
	output raster_geom_pkg::coord_t px_x,
	output raster_geom_pkg::coord_t px_y,
	output raster_geom_pkg::color_t px_color,
	output logic                    obj_done
);
	import raster_geom_pkg::*;

	// Capture stage
	logic    cap_valid;
	coord_t  cap_x0;
	coord_t  cap_y0;
	coord_t  cap_x1;
	coord_t  cap_y1;
	color_t  cap_color;
	logic    cap_end;

	// Classify stage
	logic    cls_valid;
	coord_t  cls_x0;
	coord_t  cls_y0;
	coord_t  cls_x1;
	coord_t  cls_y1;
	color_t  cls_color;
	logic    cls_end;
	delta_t  cls_dx;
	delta_t  cls_dy;
	octant_t cls_octant;

	// Normalize stage
	logic    nrm_valid;
	coord_t  nrm_sx;
	coord_t  nrm_sy;
	delta_t  nrm_major;
	delta_t  nrm_minor;
	octant_t nrm_octant;
	color_t  nrm_color;
	logic    nrm_end;

	// Queue head
	logic    q_empty;
	logic    q_pop;
	coord_t  q_sx;
	coord_t  q_sy;
	delta_t  q_major;
	delta_t  q_minor;
	octant_t q_octant;
	color_t  q_color;
	logic    q_end;

	line_capture u_capture (
		.clk       (clk),
		.rst       (rst),
		.line_valid(line_valid),
		.x0        (x0),
		.y0        (y0),
		.x1        (x1),
		.y1        (y1),
		.color     (color),
		.end_obj   (end_obj),
		.cap_valid (cap_valid),
		.cap_x0    (cap_x0),
		.cap_y0    (cap_y0),
		.cap_x1    (cap_x1),
		.cap_y1    (cap_y1),
		.cap_color (cap_color),
		.cap_end   (cap_end)
	);

	octant_classifier u_classifier (
		.clk       (clk),
		.rst       (rst),
		.cap_valid (cap_valid),
		.cap_x0    (cap_x0),
		.cap_y0    (cap_y0),
		.cap_x1    (cap_x1),
		.cap_y1    (cap_y1),
		.cap_color (cap_color),
		.cap_end   (cap_end),
		.cls_valid (cls_valid),
		.cls_x0    (cls_x0),
		.cls_y0    (cls_y0),
		.cls_x1    (cls_x1),
		.cls_y1    (cls_y1),
		.cls_color (cls_color),
		.cls_end   (cls_end),
		.cls_dx    (cls_dx),
		.cls_dy    (cls_dy),
		.cls_octant(cls_octant)
	);

	endpoint_normalizer u_normalizer (
		.clk       (clk),
		.rst       (rst),
		.cls_valid (cls_valid),
		.cls_x0    (cls_x0),
		.cls_y0    (cls_y0),
		.cls_x1    (cls_x1),
		.cls_y1    (cls_y1),
		.cls_color (cls_color),
		.cls_end   (cls_end),
		.cls_dx    (cls_dx),
		.cls_dy    (cls_dy),
		.cls_octant(cls_octant),
		.nrm_valid (nrm_valid),
		.nrm_sx    (nrm_sx),
		.nrm_sy    (nrm_sy),
		.nrm_major (nrm_major),
		.nrm_minor (nrm_minor),
		.nrm_octant(nrm_octant),
		.nrm_color (nrm_color),
		.nrm_end   (nrm_end)
	);

	line_queue u_queue (
		.clk        (clk),
		.rst        (rst),
		.nrm_valid  (nrm_valid),
		.nrm_sx     (nrm_sx),
		.nrm_sy     (nrm_sy),
		.nrm_major  (nrm_major),
		.nrm_minor  (nrm_minor),
		.nrm_octant (nrm_octant),
		.nrm_color  (nrm_color),
		.nrm_end    (nrm_end),
		.q_pop      (q_pop),
		.q_empty    (q_empty),
		.q_sx       (q_sx),
		.q_sy       (q_sy),
		.q_major    (q_major),
		.q_minor    (q_minor),
		.q_octant   (q_octant),
		.q_color    (q_color),
		.q_end      (q_end),
		.line_credit(line_credit)
	);

	bresenham_walker u_walker (
		.clk      (clk),
		.rst      (rst),
		.q_empty  (q_empty),
		.q_sx     (q_sx),
		.q_sy     (q_sy),
		.q_major  (q_major),
		.q_minor  (q_minor),
		.q_octant (q_octant),
		.q_color  (q_color),
		.q_end    (q_end),
		.q_pop    (q_pop),
		.px_credit(px_credit),
		.px_valid (px_valid),
		.px_x     (px_x),
		.px_y     (px_y),
		.px_color (px_color),
		.obj_done (obj_done)
	);

endmodule

`default_nettype wire

/* tb/rasterizer_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "raster_settings.svh"

module rasterizer_tb;
	import raster_geom_pkg::*;

	localparam int CLK_HALF     = 20;
	localparam int CLK_PERIOD   = 2 * CLK_HALF;
	localparam int RESET_CYCLES = 8;
	localparam int QDEPTH       = `RASTER_QUEUE_DEPTH;
	localparam int PX_INIT      = `RASTER_PX_CREDITS;
	localparam int SEED         = 32'h5e25_5152;

	logic   clk = 1'b0;
	logic   rst;
	logic   line_valid;
	coord_t x0;
	coord_t y0;
	coord_t x1;
	coord_t y1;
	color_t color;
	logic   end_obj;
	logic   line_credit;
	logic   px_credit;
	logic   px_valid;
	coord_t px_x;
	coord_t px_y;
	color_t px_color;
	logic   obj_done;

	// Lines from the trace and the pixels expected from them
	int ln_x0[$];
	int ln_y0[$];
	int ln_x1[$];
	int ln_y1[$];
	int ln_color[$];
	int ln_end[$];
	int exp_x[$];
	int exp_y[$];
	int exp_color[$];
	int exp_done[$];
	int n_lines;
	int n_px;
	int n_ends;
	logic trace_loaded = 1'b0;
	logic run = 1'b0;

	integer seed_gap;
	integer seed_grant;
	int sender_credits = QDEPTH;
	int next_line = 0;
	int line_credits_back = 0;
	int grants_applied = 0;
	int px_used = 0;
	int grants_seen = 0;
	int px_seen = 0;
	int done_pulses = 0;

	rasterizer_top UUT (
		.clk        (clk),
		.rst        (rst),
		.line_valid (line_valid),
		.x0         (x0),
		.y0         (y0),
		.x1         (x1),
		.y1         (y1),
		.color      (color),
		.end_obj    (end_obj),
		.line_credit(line_credit),
		.px_credit  (px_credit),
		.px_valid   (px_valid),
		.px_x       (px_x),
		.px_y       (px_y),
		.px_color   (px_color),
		.obj_done   (obj_done)
	);

	always #CLK_HALF clk = ~clk;

	task automatic abort_run(input string what);
		$display("ERROR at %0t ns: %s", $time, what);
		$display("=== FAIL ===");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic report_mismatch(input string name, input int expected, input int actual);
		$display("CHECK FAILED at %0t ns: %s expected %0d, got %0d", $time, name, expected,
			actual);
		$display("=== FAIL ===");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic load_trace();
		int fd;
		int n;
		int a;
		int b;
		int c;
		int d;
		int e;
		int f;
		int dx;
		int dy;
		int count;
		logic reading;
		logic [63:0] tag;
		logic [8*256-1:0] skip_line;
		fd = $fopen("tb/line_trace.txt", "r");
		if (fd == 0)
			abort_run("cannot open the trace file tb/line_trace.txt");
		reading = 1'b1;
		while (reading)
		begin
			n = $fscanf(fd, "%s", tag);
			if (n != 1)
				reading = 1'b0;
			else if (tag == "#")
				n = $fgets(skip_line, fd);
			else if (tag == "L")
			begin
				n = $fscanf(fd, "%d %d %d %d %d %d", a, b, c, d, e, f);
				if (n != 6)
					abort_run("malformed line record in the trace file");
				ln_x0.push_back(a);
				ln_y0.push_back(b);
				ln_x1.push_back(c);
				ln_y1.push_back(d);
				ln_color.push_back(e);
				ln_end.push_back(f);
			end
			else if (tag == "P")
			begin
				n = $fscanf(fd, "%d %d %d", a, b, c);
				if (n != 3)
					abort_run("malformed pixel record in the trace file");
				exp_x.push_back(a);
				exp_y.push_back(b);
				exp_color.push_back(c);
			end
			else
				abort_run("unknown record type in the trace file");
		end
		$fclose(fd);
		n_lines = ln_x0.size();
		n_px = exp_x.size();
		n_ends = 0;
		// A line gives its major delta plus one pixels and obj_done marks the last
		for (int i = 0; i < n_lines; i++)
		begin
			dx = (ln_x1[i] > ln_x0[i]) ? ln_x1[i] - ln_x0[i] : ln_x0[i] - ln_x1[i];
			dy = (ln_y1[i] > ln_y0[i]) ? ln_y1[i] - ln_y0[i] : ln_y0[i] - ln_y1[i];
			count = ((dx > dy) ? dx : dy) + 1;
			for (int k = 0; k < count; k++)
				exp_done.push_back((k == count - 1) && (ln_end[i] != 0));
			if (ln_end[i] != 0)
				n_ends = n_ends + 1;
		end
		if (exp_done.size() != n_px)
			abort_run("pixel records in the trace do not match the lengths of its lines");
		trace_loaded = 1'b1;
	endtask

	task automatic check_pixel();
		assert (px_seen < n_px)
		else abort_run("a pixel came out after the last expected pixel");
		assert (px_seen + 1 <= PX_INIT + grants_seen)
		else abort_run("more pixels were sent than pixel credits granted");
		assert (px_x == exp_x[px_seen]) else report_mismatch("px_x", exp_x[px_seen], px_x);
		assert (px_y == exp_y[px_seen]) else report_mismatch("px_y", exp_y[px_seen], px_y);
		assert (px_color == exp_color[px_seen])
		else report_mismatch("px_color", exp_color[px_seen], px_color);
		assert (obj_done == exp_done[px_seen])
		else report_mismatch("obj_done", exp_done[px_seen], obj_done);
		px_seen = px_seen + 1;
	endtask

	initial
	begin
		rst = 1'b0;
		line_valid = 1'b0;
		x0 = '0;
		y0 = '0;
		x1 = '0;
		y1 = '0;
		color = '0;
		end_obj = 1'b0;
		px_credit = 1'b0;
		seed_gap = SEED;
		seed_grant = SEED;
		load_trace();
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;
		@(posedge clk);
		run = 1'b1;
		wait (px_seen == n_px);
		// Let the last line credit come back
		repeat (4) @(posedge clk);
		assert (next_line == n_lines) else report_mismatch("lines sent", n_lines, next_line);
		assert (line_credits_back == n_lines)
		else report_mismatch("line_credit pulses", n_lines, line_credits_back);
		assert (done_pulses == n_ends)
		else report_mismatch("obj_done pulses", n_ends, done_pulses);
		$display("=== PASS ===");
		$finish;
	end

	initial
	begin
		wait (trace_loaded);
		#(((n_px + 8 * n_lines) * 4 + RESET_CYCLES) * CLK_PERIOD);
		abort_run("timeout, the pixel stream did not finish in time");
	end

	// Clipper sends one line per credit with random gaps
	always @(negedge clk)
	begin
		if (run)
		begin
			if (line_credit)
			begin
				line_credits_back = line_credits_back + 1;
				sender_credits = sender_credits + 1;
			end
			assert (sender_credits >= 0 && sender_credits <= QDEPTH)
			else abort_run("line credit count of the sender left its range");
			if (sender_credits > 0 && next_line < n_lines && ($random(seed_gap) & 3) != 0)
			begin
				x0 = coord_t'(ln_x0[next_line]);
				y0 = coord_t'(ln_y0[next_line]);
				x1 = coord_t'(ln_x1[next_line]);
				y1 = coord_t'(ln_y1[next_line]);
				color = color_t'(ln_color[next_line]);
				end_obj = ln_end[next_line] != 0;
				line_valid = 1'b1;
				sender_credits = sender_credits - 1;
				next_line = next_line + 1;
			end
			else
				line_valid = 1'b0;
		end
	end

	// Frame buffer grants at random up to the walker's credit limit
	always @(negedge clk)
	begin
		int on_hand;
		if (run)
		begin
			if (px_credit)
				grants_applied = grants_applied + 1;
			on_hand = PX_INIT + grants_applied - px_used;
			if (px_valid)
				px_used = px_used + 1;
			if (on_hand - px_valid < PX_INIT && ($random(seed_grant) & 1) != 0)
				px_credit = 1'b1;
			else
				px_credit = 1'b0;
		end
	end

	always @(posedge clk)
	begin
		if (px_credit)
			grants_seen = grants_seen + 1;
	end

	always @(negedge clk)
	begin
		if (!run)
		begin
			assert (!px_valid && !line_credit && !obj_done)
			else abort_run("an output was active during reset");
		end
		else
		begin
			if (obj_done)
				done_pulses = done_pulses + 1;
			if (px_valid)
				check_pixel();
			else
				assert (!obj_done) else abort_run("obj_done pulsed without a pixel");
		end
	end

endmodule

`default_nettype wire

/* rasterizer_top.f */
+incdir+include
rtl/raster_geom_pkg.sv
rtl/raster_ctl_pkg.sv
rtl/line_capture.sv
rtl/octant_classifier.sv
rtl/endpoint_normalizer.sv
rtl/line_queue.sv
rtl/bresenham_walker.sv
rtl/rasterizer_top.sv
tb/rasterizer_tb.sv

/* tb/line_trace.txt */
# L x0 y0 x1 y1 color end_obj, then P x y color for each pixel of that line in walk order
# Each line is walked from the end that is lower on its major axis
L 10 10 14 10 1 0
P 10 10 1  P 11 10 1  P 12 10 1  P 13 10 1  P 14 10 1
L 20 25 20 22 2 1
P 20 22 2  P 20 23 2  P 20 24 2  P 20 25 2
L 5 5 8 8 3 0
P 5 5 3  P 6 6 3  P 7 7 3  P 8 8 3
L 9 2 3 5 4 1
P 3 5 4  P 4 5 4  P 5 4 4  P 6 4 4  P 7 3 4  P 8 3 4  P 9 2 4
L 0 0 2 5 5 0
P 0 0 5  P 0 1 5  P 1 2 5  P 1 3 5  P 2 4 5  P 2 5 5
L 3 10 7 4 6 1
P 7 4 6  P 6 5 6  P 6 6 6  P 5 7 6  P 4 8 6  P 4 9 6  P 3 10 6
L 12 13 12 13 7 1
P 12 13 7
L 0 3 3 1 1 0
P 0 3 1  P 1 2 1  P 2 2 1  P 3 1 1
L 4 3 0 1 2 0
P 0 1 2  P 1 1 2  P 2 2 2  P 3 2 2  P 4 3 2
L 2 0 1 3 3 0
P 2 0 3  P 2 1 3  P 1 2 3  P 1 3 3
L 5 4 4 0 4 1
P 4 0 4  P 4 1 4  P 4 2 4  P 5 3 4  P 5 4 4
